/* meta_pkg.sv */
// Shared widths, counts and request word layout for the request front end

package meta_pkg;

    // ------------------------------
    // Stream and word sizes
    // ------------------------------

    // Independent request streams into the arbiter
    localparam int N_STREAMS = 4;
    // Bits needed to name one stream
    localparam int STREAM_W = 2;
    // Width of one request word
    localparam int WORD_W = 64;

    // ------------------------------
    // Transfer geometry
    // ------------------------------

    // Byte address of a transfer
    localparam int ADDR_W = 48;
    // Beat count of a transfer
    localparam int LEN_W = 12;
    // Marker tag
    localparam int TAG_W = 32;
    // Bytes moved per beat
    localparam int BEAT_BYTES = 64;
    // Longest burst handed to the memory engine, in beats
    localparam int MAX_BURST = 16;

    // Padding so both views fill the word exactly
    localparam int XFER_SPARE_W = WORD_W - 1 - STREAM_W - ADDR_W - LEN_W;
    localparam int MARKER_RSVD_W = WORD_W - 1 - STREAM_W - TAG_W;

    // ------------------------------
    // Request word views
    // ------------------------------

    typedef enum logic [0:0] {
        KIND_TRANSFER = 1'b0,
        KIND_MARKER = 1'b1
    } req_kind_e;

    // Kind and stream lead both views at the same bit positions
    typedef struct packed {
        req_kind_e kind;
        logic [STREAM_W-1:0] stream;
        logic [ADDR_W-1:0] vaddr;
        logic [LEN_W-1:0] len;
        logic [XFER_SPARE_W-1:0] spare;
    } req_transfer_t;

    typedef struct packed {
        req_kind_e kind;
        logic [STREAM_W-1:0] stream;
        logic [TAG_W-1:0] tag;
        logic [MARKER_RSVD_W-1:0] rsvd;
    } req_marker_t;

    // One 64-bit word, decoded by its kind bit
    typedef union packed {
        req_transfer_t transfer;
        req_marker_t marker;
    } req_word_t;

endpackage

/* meta_arbiter.sv */
`timescale 1ns/100ps

// Round-robin merge of the request streams onto one registered output
//
// Each stream owns a one-word buffer. The pointer's stream wins when its
// buffer is full, otherwise the highest-numbered full buffer is taken,
// so the output never sits idle while a word waits. A backlogged stream
// waits behind at most N_STREAMS - 1 other issued words.
module meta_arbiter (
    input  logic clk,
    input  logic reset_synced,

    // Request streams from the outside
    input  logic [meta_pkg::N_STREAMS-1:0] in_valid,
    output logic [meta_pkg::N_STREAMS-1:0] in_ready,
    input  meta_pkg::req_word_t [meta_pkg::N_STREAMS-1:0] in_data,

    // Merged output towards the splitter
    output logic arb_valid,
    input  logic arb_ready,
    output meta_pkg::req_word_t arb_data
);

    // Stream favoured by round-robin for the next issue
    logic [meta_pkg::STREAM_W-1:0] rr_ptr;
    // Stream actually chosen this cycle
    logic [meta_pkg::STREAM_W-1:0] sel;

    // One word of storage per stream
    meta_pkg::req_word_t [meta_pkg::N_STREAMS-1:0] buf_data;
    logic [meta_pkg::N_STREAMS-1:0] buf_valid;

    // Selected buffer drains at this edge
    logic issue;

    assign issue = arb_ready && buf_valid[sel];

    // ------------------------------
    // Input side
    // ------------------------------

    // Ready when empty or when the buffer empties at this very edge
    always_comb begin
        for (int i = 0; i < meta_pkg::N_STREAMS; i++) begin
            in_ready[i] = !buf_valid[i]
                || (sel == meta_pkg::STREAM_W'(i) && arb_ready);
        end
    end

    // Buffer flags refill in the same cycle they drain
    always_ff @(posedge clk) begin
        if (reset_synced == 1'b0) begin
            buf_valid <= '0;
        end else begin
            for (int i = 0; i < meta_pkg::N_STREAMS; i++) begin
                if (in_ready[i]) begin
                    // Empty or draining now so the new state is the input's
                    buf_valid[i] <= in_valid[i];
                end
            end
        end
    end

    // Buffer payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < meta_pkg::N_STREAMS; i++) begin
            if (in_ready[i] && in_valid[i]) begin
                buf_data[i] <= in_data[i];
            end
        end
    end

    // ------------------------------
    // Selection
    // ------------------------------

    always_comb begin
        // Stream 0 when nothing is buffered and nothing issues
        sel = '0;
        if (buf_valid[rr_ptr]) begin
            sel = rr_ptr;
        end else begin
            // Ascending scan leaves the highest full buffer as the last hit
            for (int i = 0; i < meta_pkg::N_STREAMS; i++) begin
                if (buf_valid[i]) begin
                    sel = meta_pkg::STREAM_W'(i);
                end
            end
        end
    end

    // ------------------------------
    // Output register and pointer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset_synced == 1'b0) begin
            arb_valid <= 1'b0;
            rr_ptr <= '0;
        end else if (arb_ready) begin
            // Output only moves while the splitter takes words
            arb_valid <= buf_valid[sel];
            if (issue) begin
                if (rr_ptr == meta_pkg::STREAM_W'(meta_pkg::N_STREAMS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    // Payload follows the selected buffer
    always_ff @(posedge clk) begin
        if (issue) begin
            arb_data <= buf_data[sel];
        end
    end

endmodule

/* req_splitter.sv */
`timescale 1ns/100ps

// Cuts merged transfer requests into bursts of at most MAX_BURST beats
//
// The accepted word sits in a register together with a running address
// and the beats still to go. Each accepted output cycle emits one burst
// and moves the address on. Markers and zero-length transfers leave in
// a single piece with their content unchanged.
module req_splitter (
    input  logic clk,
    input  logic reset_synced,

    // Merged words from the arbiter
    input  logic arb_valid,
    output logic arb_ready,
    input  meta_pkg::req_word_t arb_data,

    // Bursts and markers towards the memory engine
    output logic out_valid,
    input  logic out_ready,
    output meta_pkg::req_word_t out_data
);

    // Address step of one full burst, in bytes
    localparam logic [meta_pkg::ADDR_W-1:0] BURST_STEP =
        meta_pkg::ADDR_W'(meta_pkg::MAX_BURST * meta_pkg::BEAT_BYTES);
    localparam logic [meta_pkg::LEN_W-1:0] BURST_LEN =
        meta_pkg::LEN_W'(meta_pkg::MAX_BURST);

    // Word being worked on
    meta_pkg::req_word_t cur_word;
    // Address of the burst on the output
    logic [meta_pkg::ADDR_W-1:0] run_addr;
    // Beats left, the current burst included
    logic [meta_pkg::LEN_W-1:0] rem_len;

    logic is_marker;
    logic last_piece;
    logic [meta_pkg::LEN_W-1:0] burst_len;
    logic take_in;
    logic take_out;

    // ------------------------------
    // Decode of the held word
    // ------------------------------

    // Kind sits at the same place in both views
    assign is_marker = (cur_word.marker.kind == meta_pkg::KIND_MARKER);

    // Full bursts until the remainder fits in one
    assign burst_len = (rem_len > BURST_LEN) ? BURST_LEN : rem_len;

    // Markers and short remainders finish with this piece
    assign last_piece = is_marker || (rem_len <= BURST_LEN);

    // Output built from registers only
    always_comb begin
        out_data = cur_word;
        if (!is_marker) begin
            out_data.transfer.vaddr = run_addr;
            out_data.transfer.len = burst_len;
        end
    end

    // ------------------------------
    // Handshakes
    // ------------------------------

    assign take_out = out_valid && out_ready;

    // Free now, or freed by the final piece leaving at this edge
    assign arb_ready = !out_valid || (last_piece && out_ready);

    assign take_in = arb_valid && arb_ready;

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset_synced == 1'b0) begin
            out_valid <= 1'b0;
        end else if (take_in) begin
            out_valid <= 1'b1;
        end else if (take_out && last_piece) begin
            out_valid <= 1'b0;
        end
    end

    // ------------------------------
    // Payload and burst counters
    // ------------------------------

    always_ff @(posedge clk) begin
        if (take_in) begin
            // Load a new word, counters start from its own fields
            cur_word <= arb_data;
            run_addr <= arb_data.transfer.vaddr;
            rem_len <= arb_data.transfer.len;
        end else if (take_out && !last_piece) begin
            // One full burst gone, step to the next one
            run_addr <= run_addr + BURST_STEP;
            rem_len <= rem_len - BURST_LEN;
        end
    end

endmodule

/* meta_req_top.sv */
`timescale 1ns/100ps

// Request front end, four streams merged and split into bursts
//
// Path from an input handshake to out_valid is three cycles at best:
// one into the stream buffer, one into the arbiter output register
// and one into the splitter. Back-pressure on out_ready reaches the
// inputs through the same chain with no word dropped.
module meta_req_top (
    input  logic clk,
    input  logic reset_synced,

    // ------------------------------
    // Request streams
    // ------------------------------
    input  logic [meta_pkg::N_STREAMS-1:0] in_valid,
    output logic [meta_pkg::N_STREAMS-1:0] in_ready,
    input  meta_pkg::req_word_t [meta_pkg::N_STREAMS-1:0] in_data,

    // ------------------------------
    // Burst output
    // ------------------------------
    output logic out_valid,
    input  logic out_ready,
    output meta_pkg::req_word_t out_data
);

    // Merged stream between arbiter and splitter
    logic arb_valid;
    logic arb_ready;
    meta_pkg::req_word_t arb_data;

    // Round-robin merge of the input streams
    meta_arbiter u_arbiter (
        .clk          (clk),
        .reset_synced (reset_synced),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .arb_valid    (arb_valid),
        .arb_ready    (arb_ready),
        .arb_data     (arb_data)
    );

    // Burst cutting of transfers, markers pass as they are
    req_splitter u_splitter (
        .clk          (clk),
        .reset_synced (reset_synced),
        .arb_valid    (arb_valid),
        .arb_ready    (arb_ready),
        .arb_data     (arb_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

endmodule

/* tb_meta_req_tasks.svh */
// ------------------------------
// Compare tasks
// ------------------------------

// Kind and stream always and then the fields of the expected view
task automatic check_word(input meta_pkg::req_word_t exp, input meta_pkg::req_word_t act);
    if (act.transfer.kind !== exp.transfer.kind) begin
        $display("Mismatch out_data.kind: expected %h, got %h",
            exp.transfer.kind, act.transfer.kind);
        abort_run();
    end
    if (act.transfer.stream !== exp.transfer.stream) begin
        $display("Mismatch out_data.stream: expected %h, got %h",
            exp.transfer.stream, act.transfer.stream);
        abort_run();
    end
    if (exp.transfer.kind == meta_pkg::KIND_MARKER) begin
        if (act.marker.tag !== exp.marker.tag) begin
            $display("Mismatch out_data.marker.tag: expected %h, got %h",
                exp.marker.tag, act.marker.tag);
            abort_run();
        end
    end else begin
        if (act.transfer.vaddr !== exp.transfer.vaddr) begin
            $display("Mismatch out_data.transfer.vaddr: expected %h, got %h",
                exp.transfer.vaddr, act.transfer.vaddr);
            abort_run();
        end
        if (act.transfer.len !== exp.transfer.len) begin
            $display("Mismatch out_data.transfer.len: expected %h, got %h",
                exp.transfer.len, act.transfer.len);
            abort_run();
        end
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Mismatch %s: expected %h, got %h", name, exp, act);
        abort_run();
    end
endtask

// ------------------------------
// Request builders
// ------------------------------

task automatic queue_marker(input int s, input logic [meta_pkg::TAG_W-1:0] tag);
    meta_pkg::req_word_t w;
    w = '0;
    w.marker.kind = meta_pkg::KIND_MARKER;
    w.marker.stream = meta_pkg::STREAM_W'(s);
    w.marker.tag = tag;
    send_q[s].push_back(w);
    // Markers leave exactly as they came
    expect_q[s].push_back(w);
endtask

// Expected bursts with burst k starting k full bursts past the base
task automatic queue_transfer(input int s, input logic [meta_pkg::ADDR_W-1:0] base,
                              input logic [meta_pkg::LEN_W-1:0] beats);
    meta_pkg::req_word_t w;
    meta_pkg::req_word_t piece;
    int n_bursts;
    int k;
    w = '0;
    w.transfer.kind = meta_pkg::KIND_TRANSFER;
    w.transfer.stream = meta_pkg::STREAM_W'(s);
    w.transfer.vaddr = base;
    w.transfer.len = beats;
    send_q[s].push_back(w);
    if (beats == '0) begin
        expect_q[s].push_back(w);
    end else begin
        n_bursts = (int'(beats) + meta_pkg::MAX_BURST - 1) / meta_pkg::MAX_BURST;
        for (k = 0; k < n_bursts; k++) begin
            piece = w;
            piece.transfer.vaddr = base
                + meta_pkg::ADDR_W'(k * meta_pkg::MAX_BURST * meta_pkg::BEAT_BYTES);
            // Only the last burst may be short
            if (k == n_bursts - 1) begin
                piece.transfer.len = meta_pkg::LEN_W'(int'(beats) - k * meta_pkg::MAX_BURST);
            end else begin
                piece.transfer.len = meta_pkg::LEN_W'(meta_pkg::MAX_BURST);
            end
            expect_q[s].push_back(piece);
        end
    end
endtask

// Output stays quiet once everything expected has left
task automatic expect_idle(input int cycles);
    out_ready = 1'b1;
    repeat (cycles) begin
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        @(posedge clk);
        #2;
    end
endtask

// A stream sees at most N_STREAMS - 1 other words before each of its own
task automatic check_rotation();
    int last_seen [meta_pkg::N_STREAMS];
    int idx;
    int s;
    int gap;
    for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
        last_seen[s] = -1;
    end
    for (idx = 0; idx < out_order.size(); idx++) begin
        s = out_order[idx];
        gap = idx - last_seen[s] - 1;
        if (gap > meta_pkg::N_STREAMS - 1) begin
            $display("Stream %0d waited behind %0d words of other streams, more than %0d",
                s, gap, meta_pkg::N_STREAMS - 1);
            abort_run();
        end
        last_seen[s] = idx;
    end
endtask

// ------------------------------
// Directed tests
// ------------------------------

task automatic test_single_marker();
    // Nothing comes out before anything goes in
    repeat (6) begin
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("in_ready[2]", 1'b1, in_ready[2]);
        @(posedge clk);
        #2;
    end
    out_order.delete();
    queue_marker(2, 32'hcafe_0002);
    run_traffic(200, 1'b0);
    expect_idle(4);
endtask

task automatic test_transfer_split();
    out_order.delete();
    queue_transfer(1, 48'h0000_1000_0000, 12'd1);
    queue_transfer(1, 48'h0000_2000_0040, 12'd16);
    queue_transfer(1, 48'h0000_3000_0000, 12'd17);
    queue_transfer(1, 48'h0000_4000_1fc0, 12'd40);
    queue_transfer(1, 48'h0000_5000_0000, 12'd0);
    run_traffic(400, 1'b0);
    expect_idle(4);
endtask

task automatic test_fairness();
    int s;
    int i;
    out_order.delete();
    for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
        for (i = 0; i < 8; i++) begin
            queue_marker(s, 32'(s * 256 + i));
        end
    end
    run_traffic(400, 1'b0);
    check_rotation();
    expect_idle(4);
endtask

task automatic test_sparse_stream();
    int i;
    out_order.delete();
    // Pointer moves past stream 3 and the fallback must still pick it
    for (i = 0; i < 6; i++) begin
        queue_marker(3, 32'h5a00_0000 + 32'(i));
    end
    run_traffic(200, 1'b0);
    expect_idle(4);
endtask

task automatic test_back_pressure();
    int s;
    int i;
    logic [meta_pkg::ADDR_W-1:0] base;
    logic [meta_pkg::LEN_W-1:0] beats;
    out_order.delete();
    for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
        for (i = 0; i < 12; i++) begin
            if (($urandom % 3) == 0) begin
                queue_marker(s, $urandom);
            end else begin
                base = meta_pkg::ADDR_W'({$urandom, $urandom});
                beats = meta_pkg::LEN_W'($urandom % 41);
                queue_transfer(s, base, beats);
            end
        end
    end
    run_traffic(8000, 1'b1);
    expect_idle(4);
endtask

/* tb_meta_req.sv */
`timescale 1ns/100ps

// Testbench for the request front end
//
// One process drives all four stream ports and out_ready and watches the
// output. Expected words sit in one queue per stream, matched by the
// stream field of each output word.
module tb_meta_req;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic clk;
    logic reset_synced;
    logic [meta_pkg::N_STREAMS-1:0] in_valid;
    logic [meta_pkg::N_STREAMS-1:0] in_ready;
    meta_pkg::req_word_t [meta_pkg::N_STREAMS-1:0] in_data;
    logic out_valid;
    logic out_ready;
    meta_pkg::req_word_t out_data;

    // ------------------------------
    // Scoreboard state
    // ------------------------------

    // Words still to be offered on each stream
    meta_pkg::req_word_t send_q [meta_pkg::N_STREAMS][$];
    // Output words each stream still owes in order
    meta_pkg::req_word_t expect_q [meta_pkg::N_STREAMS][$];
    // Source stream of every output word of the current test
    int out_order [$];

    // Stalled output seen at the last sample
    logic held_valid;
    meta_pkg::req_word_t held_word;

    // Stops the run at the first error
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_meta_req_tasks.svh"

    // ------------------------------
    // Output monitor
    // ------------------------------

    // Matches one accepted output word against its stream's queue
    task automatic take_output(input meta_pkg::req_word_t act);
        int s;
        meta_pkg::req_word_t exp;
        s = int'(act.transfer.stream);
        if (expect_q[s].size() == 0) begin
            $display("Output word %h came from stream %0d with nothing expected there", act, s);
            abort_run();
        end
        exp = expect_q[s].pop_front();
        check_word(exp, act);
        out_order.push_back(s);
    endtask

    // Called mid-cycle where every output is settled
    task automatic watch_output();
        // A stalled word must still be there untouched
        if (held_valid) begin
            check_flag("out_valid", 1'b1, out_valid);
            check_word(held_word, out_data);
        end
        if (out_valid && out_ready) begin
            take_output(out_data);
        end
        held_valid = out_valid && !out_ready;
        held_word = out_data;
    endtask

    function automatic bit traffic_pending();
        bit busy;
        int s;
        busy = (in_valid != '0);
        for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
            if (send_q[s].size() != 0 || expect_q[s].size() != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // ------------------------------
    // Traffic loop
    // ------------------------------

    // Runs until every queued word went in and every expected word came out
    task automatic run_traffic(input int limit, input bit random_ready);
        int cycles;
        int s;
        bit taken [meta_pkg::N_STREAMS];
        cycles = 0;
        held_valid = 1'b0;
        while (traffic_pending()) begin
            // Offer the next word wherever a port is free
            for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
                if (!in_valid[s] && send_q[s].size() != 0) begin
                    in_data[s] = send_q[s].pop_front();
                    in_valid[s] = 1'b1;
                end
            end
            if (random_ready) begin
                out_ready = ($urandom & 1) != 0;
            end else begin
                out_ready = 1'b1;
            end
            @(negedge clk);
            watch_output();
            // Handshakes that complete at the coming edge
            for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
                taken[s] = in_valid[s] && in_ready[s];
            end
            @(posedge clk);
            #2;
            for (s = 0; s < meta_pkg::N_STREAMS; s++) begin
                if (taken[s]) begin
                    in_valid[s] = 1'b0;
                end
            end
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: requests not all accepted and output within %0d cycles",
                    limit);
                abort_run();
            end
        end
    endtask

    // ------------------------------
    // Clock, reset and DUT
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    meta_req_top uut (
        .clk          (clk),
        .reset_synced (reset_synced),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    initial begin
        in_valid = '0;
        in_data = '0;
        out_ready = 1'b0;
        reset_synced = 1'b0;
        held_valid = 1'b0;
        held_word = '0;
        void'($urandom(32'h6c02));
        repeat (10) @(posedge clk);
        #2;
        reset_synced = 1'b1;

        test_single_marker();
        test_transfer_split();
        test_fairness();
        test_sparse_stream();
        test_back_pressure();

        $display("TEST OK");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
meta_pkg.sv
meta_arbiter.sv
req_splitter.sv
meta_req_top.sv
tb_meta_req.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the request front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_meta_req \
    -o tb_meta_req

# Exit status is non-zero when the testbench stops on $fatal
./obj_dir/tb_meta_req
